// ==== Makefile ====
# Verilator build and run for the ID stage

VERILATOR ?= verilator
TOP       ?= tb_id_stage
FILELIST  ?= id_stage.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed!
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_MSG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hdl/branch_issue.sv ====
`timescale 1ns/1ps

module branch_issue import mips_id_pkg::*; (
	input  logic                    clk_i,
	input  logic                    rst_i,
	input  logic                    valid_i,
	input  logic [WORD_W-1:0]       pc_i,
	input  logic [WORD_W-1:0]       inst_i,
	input  alu_op_e                 aluop_i,
	input  alu_sel_e                alusel_i,
	input  logic [REG_ADDR_W-1:0]   wd_i,
	input  logic                    wreg_i,
	input  logic                    jump_i,
	input  logic                    cond_branch_i,
	input  logic [WORD_W-1:0]       reg1_i,
	input  logic [WORD_W-1:0]       reg2_i,
	output logic                    valid_o,
	output alu_op_e                 aluop_o,
	output alu_sel_e                alusel_o,
	output logic [REG_ADDR_W-1:0]   wd_o,
	output logic                    wreg_o,
	output logic [WORD_W-1:0]       reg1_o,
	output logic [WORD_W-1:0]       reg2_o,
	output logic                    branch_flag_o,
	output logic [WORD_W-1:0]       branch_target_o,
	output logic [WORD_W-1:0]       link_addr_o,
	output logic                    next_inst_in_delayslot_o
);

	logic [WORD_W-1:0] pc_plus4;
	logic [WORD_W-1:0] br_offset;
	logic [WORD_W-1:0] jump_addr;
	logic [WORD_W-1:0] target;
	logic              cond_met;
	logic              taken;
	logic              reg1_zero;

	assign pc_plus4  = pc_i + WORD_W'(4);
	assign br_offset = {{14{inst_i[15]}}, inst_i[15:0], 2'b00};
	assign jump_addr = {pc_plus4[WORD_W-1 -: 4], inst_i[25:0], 2'b00};
	assign reg1_zero = (reg1_i == '0);

	always_comb begin
		case (aluop_i)
			ALU_BEQ:  cond_met = (reg1_i == reg2_i);
			ALU_BNE:  cond_met = (reg1_i != reg2_i);
			ALU_BGTZ: cond_met = !reg1_i[WORD_W-1] && !reg1_zero;
			ALU_BLEZ: cond_met = reg1_i[WORD_W-1] || reg1_zero;
			ALU_BGEZ: cond_met = !reg1_i[WORD_W-1];
			ALU_BLTZ: cond_met = reg1_i[WORD_W-1];
			default:  cond_met = 1'b0;
		endcase
	end

	assign taken = jump_i || (cond_branch_i && cond_met);

	always_comb begin
		if (cond_branch_i)
			target = pc_plus4 + br_offset;
		else if (aluop_i == ALU_JR)
			target = reg1_i; // forwarded rs
		else if (jump_i)
			target = jump_addr;
		else
			target = '0;
	end

	// control toward EX, cleared on a bubble
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			valid_o                  <= 1'b0;
			aluop_o                  <= ALU_NOP;
			alusel_o                 <= SEL_NOP;
			wreg_o                   <= 1'b0;
			branch_flag_o            <= 1'b0;
			next_inst_in_delayslot_o <= 1'b0;
		end else begin
			valid_o                  <= valid_i;
			aluop_o                  <= valid_i ? aluop_i : ALU_NOP;
			alusel_o                 <= valid_i ? alusel_i : SEL_NOP;
			wreg_o                   <= valid_i && wreg_i;
			branch_flag_o            <= valid_i && taken;
			next_inst_in_delayslot_o <= valid_i && taken;
		end
	end

	always_ff @(posedge clk_i) begin
		if (valid_i) begin
			wd_o            <= wd_i;
			reg1_o          <= reg1_i;
			reg2_o          <= reg2_i;
			branch_target_o <= target;
			link_addr_o     <= (aluop_i == ALU_JAL) ? pc_i + WORD_W'(8) : '0;
		end
	end

endmodule

// ==== hdl/id_stage.sv ====
`timescale 1ns/1ps

module id_stage import mips_id_pkg::*; (
	input  logic                                      clk_i,
	input  logic                                      rst_i,
	input  logic                                      inst_valid_i,
	input  logic [WORD_W-1:0]                         inst_i,
	input  logic [WORD_W-1:0]                         pc_i,
	input  logic [NUM_OPERANDS-1:0][WORD_W-1:0]       reg_rdata_i,
	input  logic                                      ex_wreg_i,
	input  logic [REG_ADDR_W-1:0]                     ex_wd_i,
	input  logic [WORD_W-1:0]                         ex_wdata_i,
	input  alu_op_e                                   ex_aluop_i,
	input  logic                                      mem_wreg_i,
	input  logic [REG_ADDR_W-1:0]                     mem_wd_i,
	input  logic [WORD_W-1:0]                         mem_wdata_i,
	output logic                                      stall_o,
	output logic [NUM_OPERANDS-1:0][REG_ADDR_W-1:0]   reg_raddr_o,
	output logic                                      valid_o,
	output alu_op_e                                   aluop_o,
	output alu_sel_e                                  alusel_o,
	output logic [REG_ADDR_W-1:0]                     wd_o,
	output logic                                      wreg_o,
	output logic [WORD_W-1:0]                         reg1_o,
	output logic [WORD_W-1:0]                         reg2_o,
	output logic                                      branch_flag_o,
	output logic [WORD_W-1:0]                         branch_target_o,
	output logic [WORD_W-1:0]                         link_addr_o,
	output logic                                      next_inst_in_delayslot_o
);

	alu_op_e                                 dec_aluop;
	alu_sel_e                                dec_alusel;
	logic [REG_ADDR_W-1:0]                   dec_wd;
	logic                                    dec_wreg;
	logic [NUM_OPERANDS-1:0]                 dec_read_en;
	logic [WORD_W-1:0]                       dec_imm;
	logic                                    dec_jump;
	logic                                    dec_cond_branch;
	logic [NUM_OPERANDS-1:0][WORD_W-1:0]     operand;
	logic [NUM_OPERANDS-1:0]                 slot_stall;

	inst_decoder u_decoder (
		.inst_i        (inst_i),
		.pc_i          (pc_i),
		.aluop_o       (dec_aluop),
		.alusel_o      (dec_alusel),
		.wd_o          (dec_wd),
		.wreg_o        (dec_wreg),
		.read_en_o     (dec_read_en),
		.raddr_o       (reg_raddr_o),
		.imm_o         (dec_imm),
		.jump_o        (dec_jump),
		.cond_branch_o (dec_cond_branch)
	);

	for (genvar i = 0; i < NUM_OPERANDS; i++) begin : g_slot
		operand_forward u_fwd (
			.read_en_i   (dec_read_en[i]),
			.raddr_i     (reg_raddr_o[i]),
			.imm_i       (dec_imm),
			.reg_rdata_i (reg_rdata_i[i]),
			.ex_wreg_i   (ex_wreg_i),
			.ex_wd_i     (ex_wd_i),
			.ex_wdata_i  (ex_wdata_i),
			.ex_aluop_i  (ex_aluop_i),
			.mem_wreg_i  (mem_wreg_i),
			.mem_wd_i    (mem_wd_i),
			.mem_wdata_i (mem_wdata_i),
			.operand_o   (operand[i]),
			.stall_o     (slot_stall[i])
		);
	end

	assign stall_o = |slot_stall;

	branch_issue u_issue (
		.clk_i                    (clk_i),
		.rst_i                    (rst_i),
		.valid_i                  (inst_valid_i && !stall_o), // stalled word is dropped
		.pc_i                     (pc_i),
		.inst_i                   (inst_i),
		.aluop_i                  (dec_aluop),
		.alusel_i                 (dec_alusel),
		.wd_i                     (dec_wd),
		.wreg_i                   (dec_wreg),
		.jump_i                   (dec_jump),
		.cond_branch_i            (dec_cond_branch),
		.reg1_i                   (operand[0]),
		.reg2_i                   (operand[1]),
		.valid_o                  (valid_o),
		.aluop_o                  (aluop_o),
		.alusel_o                 (alusel_o),
		.wd_o                     (wd_o),
		.wreg_o                   (wreg_o),
		.reg1_o                   (reg1_o),
		.reg2_o                   (reg2_o),
		.branch_flag_o            (branch_flag_o),
		.branch_target_o          (branch_target_o),
		.link_addr_o              (link_addr_o),
		.next_inst_in_delayslot_o (next_inst_in_delayslot_o)
	);

endmodule

// ==== hdl/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder import mips_id_pkg::*; (
	input  logic [WORD_W-1:0]                         inst_i,
	input  logic [WORD_W-1:0]                         pc_i,
	output alu_op_e                                   aluop_o,
	output alu_sel_e                                  alusel_o,
	output logic [REG_ADDR_W-1:0]                     wd_o,
	output logic                                      wreg_o,
	output logic [NUM_OPERANDS-1:0]                   read_en_o,
	output logic [NUM_OPERANDS-1:0][REG_ADDR_W-1:0]   raddr_o,
	output logic [WORD_W-1:0]                         imm_o,
	output logic                                      jump_o,
	output logic                                      cond_branch_o
);

	opcode_e                 op;
	funct_e                  fn;
	regimm_e                 ri;
	logic [REG_ADDR_W-1:0]   rs;
	logic [REG_ADDR_W-1:0]   rt;
	logic [REG_ADDR_W-1:0]   rd;
	logic [WORD_W-1:0]       imm_sext;
	logic [WORD_W-1:0]       imm_zext;

	assign op = opcode_e'(inst_i[31:26]);
	assign fn = funct_e'(inst_i[5:0]);
	assign ri = regimm_e'(inst_i[20:16]);
	assign rs = inst_i[25:21];
	assign rt = inst_i[20:16];
	assign rd = inst_i[15:11];

	assign imm_sext = {{16{inst_i[15]}}, inst_i[15:0]};
	assign imm_zext = {16'h0000, inst_i[15:0]};

	function automatic alu_op_e rtype_op(funct_e f);
		case (f)
			FN_ADDU: return ALU_ADDU;
			FN_SUBU: return ALU_SUBU;
			FN_SLT:  return ALU_SLT;
			FN_SLTU: return ALU_SLTU;
			FN_AND:  return ALU_AND;
			FN_OR:   return ALU_OR;
			FN_XOR:  return ALU_XOR;
			FN_NOR:  return ALU_NOR;
			FN_SLL:  return ALU_SLL;
			FN_SRL:  return ALU_SRL;
			FN_SRA:  return ALU_SRA;
			default: return ALU_NOP;
		endcase
	endfunction

	always_comb begin
		aluop_o       = ALU_NOP;
		alusel_o      = SEL_NOP;
		wd_o          = rd;
		wreg_o        = 1'b0;
		read_en_o     = '0;
		raddr_o[0]    = rs;
		raddr_o[1]    = rt;
		imm_o         = '0;
		jump_o        = 1'b0;
		cond_branch_o = 1'b0;
		case (op)
			OP_SPECIAL: begin
				case (fn)
					FN_ADDU, FN_SUBU, FN_SLT, FN_SLTU, FN_AND, FN_OR, FN_XOR, FN_NOR: begin
						aluop_o   = rtype_op(fn);
						alusel_o  = (fn inside {FN_AND, FN_OR, FN_XOR, FN_NOR}) ? SEL_LOGIC
						                                                        : SEL_ARITH;
						wreg_o    = 1'b1;
						read_en_o = '1;
					end
					FN_SLL, FN_SRL, FN_SRA: begin
						if (rs == '0) begin // rs must be zero for shift by shamt
							aluop_o      = rtype_op(fn);
							alusel_o     = SEL_SHIFT;
							wreg_o       = 1'b1;
							read_en_o[1] = 1'b1;
							imm_o        = WORD_W'(inst_i[10:6]);
						end
					end
					FN_JR: begin
						aluop_o      = ALU_JR;
						alusel_o     = SEL_JUMP_BRANCH;
						read_en_o[0] = 1'b1;
						jump_o       = 1'b1;
					end
					FN_SYNC: ; // nop
					default: ;
				endcase
			end
			OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_LW: begin
				wd_o         = rt;
				wreg_o       = 1'b1;
				read_en_o[0] = 1'b1;
				case (op)
					OP_ADDIU: aluop_o = ALU_ADDU;
					OP_SLTI:  aluop_o = ALU_SLT;
					OP_ANDI:  aluop_o = ALU_AND;
					OP_XORI:  aluop_o = ALU_XOR;
					OP_LW:    aluop_o = ALU_LW;
					default:  aluop_o = ALU_OR; // ori, lui
				endcase
				case (op)
					OP_ADDIU, OP_SLTI: alusel_o = SEL_ARITH;
					OP_LW:             alusel_o = SEL_LOAD_STORE;
					default:           alusel_o = SEL_LOGIC;
				endcase
				if (op inside {OP_ANDI, OP_ORI, OP_XORI})
					imm_o = imm_zext;
				else if (op == OP_LUI)
					imm_o = {inst_i[15:0], 16'h0000};
				else
					imm_o = imm_sext;
				if (op == OP_LUI)
					raddr_o[0] = '0; // or with $zero
			end
			OP_SW: begin
				aluop_o   = ALU_SW;
				alusel_o  = SEL_LOAD_STORE;
				read_en_o = '1;
				imm_o     = imm_sext;
			end
			OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: begin
				alusel_o      = SEL_JUMP_BRANCH;
				cond_branch_o = 1'b1;
				read_en_o[0]  = 1'b1;
				read_en_o[1]  = (op == OP_BEQ) || (op == OP_BNE);
				case (op)
					OP_BEQ:  aluop_o = ALU_BEQ;
					OP_BNE:  aluop_o = ALU_BNE;
					OP_BLEZ: aluop_o = ALU_BLEZ;
					default: aluop_o = ALU_BGTZ;
				endcase
			end
			OP_REGIMM: begin
				if (ri == RI_BGEZ || ri == RI_BLTZ) begin
					aluop_o       = (ri == RI_BGEZ) ? ALU_BGEZ : ALU_BLTZ;
					alusel_o      = SEL_JUMP_BRANCH;
					cond_branch_o = 1'b1;
					read_en_o[0]  = 1'b1;
				end
			end
			OP_J: begin
				aluop_o  = ALU_J;
				alusel_o = SEL_JUMP_BRANCH;
				jump_o   = 1'b1;
			end
			OP_JAL: begin
				aluop_o  = ALU_JAL;
				alusel_o = SEL_JUMP_BRANCH;
				jump_o   = 1'b1;
				wreg_o   = 1'b1;
				wd_o     = LINK_REG;
				imm_o    = pc_i + WORD_W'(8); // link value rides the operand path
			end
			OP_PREF: ;
			default: ;
		endcase
	end

endmodule

// ==== hdl/mips_id_pkg.sv ====
package mips_id_pkg;

	localparam int WORD_W       = 32;
	localparam int REG_ADDR_W   = 5;
	localparam int NUM_OPERANDS = 2;

	localparam logic [REG_ADDR_W-1:0] LINK_REG = 5'd31; // written by JAL

	// primary opcodes, inst[31:26]
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'b000000,
		OP_REGIMM  = 6'b000001,
		OP_J       = 6'b000010,
		OP_JAL     = 6'b000011,
		OP_BEQ     = 6'b000100,
		OP_BNE     = 6'b000101,
		OP_BLEZ    = 6'b000110,
		OP_BGTZ    = 6'b000111,
		OP_ADDIU   = 6'b001001,
		OP_SLTI    = 6'b001010,
		OP_ANDI    = 6'b001100,
		OP_ORI     = 6'b001101,
		OP_XORI    = 6'b001110,
		OP_LUI     = 6'b001111,
		OP_LW      = 6'b100011,
		OP_SW      = 6'b101011,
		OP_PREF    = 6'b110011  // treated as nop
	} opcode_e;

	// SPECIAL function field, inst[5:0]
	typedef enum logic [5:0] {
		FN_SLL  = 6'b000000,
		FN_SRL  = 6'b000010,
		FN_SRA  = 6'b000011,
		FN_JR   = 6'b001000,
		FN_SYNC = 6'b001111,
		FN_ADDU = 6'b100001,
		FN_SUBU = 6'b100011,
		FN_AND  = 6'b100100,
		FN_OR   = 6'b100101,
		FN_XOR  = 6'b100110,
		FN_NOR  = 6'b100111,
		FN_SLT  = 6'b101010,
		FN_SLTU = 6'b101011
	} funct_e;

	// REGIMM rt field
	typedef enum logic [4:0] {
		RI_BLTZ = 5'b00000,
		RI_BGEZ = 5'b00001
	} regimm_e;

	typedef enum logic [7:0] {
		ALU_NOP  = 8'b00000000,
		ALU_AND  = 8'b00100100,
		ALU_OR   = 8'b00100101,
		ALU_XOR  = 8'b00100110,
		ALU_NOR  = 8'b00100111,
		ALU_SLL  = 8'b01111100,
		ALU_SRL  = 8'b00000010,
		ALU_SRA  = 8'b00000011,
		ALU_SLT  = 8'b00101010,
		ALU_SLTU = 8'b00101011,
		ALU_ADDU = 8'b00100001,
		ALU_SUBU = 8'b00100011,
		ALU_J    = 8'b01001111,
		ALU_JAL  = 8'b01010000,
		ALU_JR   = 8'b00001000,
		ALU_BEQ  = 8'b01010001,
		ALU_BNE  = 8'b01010010,
		ALU_BLEZ = 8'b01010011,
		ALU_BGTZ = 8'b01010100,
		ALU_BGEZ = 8'b01000001,
		ALU_BLTZ = 8'b01000000,
		ALU_LW   = 8'b11100011,
		ALU_SW   = 8'b11101011
	} alu_op_e;

	typedef enum logic [2:0] {
		SEL_NOP         = 3'b000,
		SEL_LOGIC       = 3'b001,
		SEL_SHIFT       = 3'b010,
		SEL_ARITH       = 3'b100,
		SEL_JUMP_BRANCH = 3'b110,
		SEL_LOAD_STORE  = 3'b111
	} alu_sel_e;

endpackage

// ==== hdl/operand_forward.sv ====
`timescale 1ns/1ps

module operand_forward import mips_id_pkg::*; (
	input  logic                    read_en_i,
	input  logic [REG_ADDR_W-1:0]   raddr_i,
	input  logic [WORD_W-1:0]       imm_i,
	input  logic [WORD_W-1:0]       reg_rdata_i,
	input  logic                    ex_wreg_i,
	input  logic [REG_ADDR_W-1:0]   ex_wd_i,
	input  logic [WORD_W-1:0]       ex_wdata_i,
	input  alu_op_e                 ex_aluop_i,
	input  logic                    mem_wreg_i,
	input  logic [REG_ADDR_W-1:0]   mem_wd_i,
	input  logic [WORD_W-1:0]       mem_wdata_i,
	output logic [WORD_W-1:0]       operand_o,
	output logic                    stall_o
);

	logic reads_nonzero;
	logic ex_hit;
	logic mem_hit;

	// $zero never matches a producer
	assign reads_nonzero = read_en_i && (raddr_i != '0);
	assign ex_hit        = reads_nonzero && (ex_wd_i == raddr_i);
	assign mem_hit       = reads_nonzero && mem_wreg_i && (mem_wd_i == raddr_i);

	// load data not ready until after MEM
	assign stall_o = ex_hit && (ex_aluop_i == ALU_LW);

	always_comb begin
		if (!read_en_i)
			operand_o = imm_i;
		else if (ex_hit && ex_wreg_i)
			operand_o = ex_wdata_i;
		else if (mem_hit)
			operand_o = mem_wdata_i;
		else
			operand_o = reg_rdata_i;
	end

endmodule

// ==== id_stage.f ====
hdl/mips_id_pkg.sv
hdl/inst_decoder.sv
hdl/operand_forward.sv
hdl/branch_issue.sv
hdl/id_stage.sv
test/id_stage_props.sv
test/tb_id_stage.sv

// ==== test/id_stage_props.sv ====
`timescale 1ns/1ps

module id_stage_props import mips_id_pkg::*; (
	input logic                                    clk_i,
	input logic                                    rst_i,
	input logic                                    inst_valid_i,
	input alu_op_e                                 ex_aluop_i,
	input logic [REG_ADDR_W-1:0]                   ex_wd_i,
	input logic [NUM_OPERANDS-1:0][REG_ADDR_W-1:0] reg_raddr_o,
	input logic                                    stall_o,
	input logic                                    valid_o,
	input alu_op_e                                 aluop_o,
	input alu_sel_e                                alusel_o,
	input logic                                    wreg_o,
	input logic                                    branch_flag_o,
	input logic                                    next_inst_in_delayslot_o
);

	int fail_count = 0;

	// load-use stall drops the word
	a_stall_bubble: assert property (@(posedge clk_i) disable iff (rst_i)
		stall_o |=> !valid_o)
	else begin
		fail_count = fail_count + 1;
		$error("stalled instruction still reached valid_o");
	end

	a_stall_cause: assert property (@(posedge clk_i) disable iff (rst_i)
		stall_o |-> (ex_aluop_i == ALU_LW) && (ex_wd_i != '0) &&
		            ((reg_raddr_o[0] == ex_wd_i) || (reg_raddr_o[1] == ex_wd_i)))
	else begin
		fail_count = fail_count + 1;
		$error("stall_o raised without a pending load to a read register");
	end

	a_accept: assert property (@(posedge clk_i) disable iff (rst_i)
		inst_valid_i && !stall_o |=> valid_o)
	else begin
		fail_count = fail_count + 1;
		$error("accepted instruction did not show up one cycle later");
	end

	a_no_strobe: assert property (@(posedge clk_i) disable iff (rst_i)
		!inst_valid_i |=> !valid_o)
	else begin
		fail_count = fail_count + 1;
		$error("valid_o high without a strobe");
	end

	// bubble carries no control
	a_bubble_clean: assert property (@(posedge clk_i) disable iff (rst_i)
		!valid_o |-> !wreg_o && !branch_flag_o && !next_inst_in_delayslot_o &&
		             (aluop_o == ALU_NOP) && (alusel_o == SEL_NOP))
	else begin
		fail_count = fail_count + 1;
		$error("control outputs active on a bubble");
	end

	a_reset: assert property (@(posedge clk_i) rst_i |=> !valid_o)
	else begin
		fail_count = fail_count + 1;
		$error("valid_o high right after reset");
	end

endmodule

bind id_stage id_stage_props u_props (
	.clk_i                    (clk_i),
	.rst_i                    (rst_i),
	.inst_valid_i             (inst_valid_i),
	.ex_aluop_i               (ex_aluop_i),
	.ex_wd_i                  (ex_wd_i),
	.reg_raddr_o              (reg_raddr_o),
	.stall_o                  (stall_o),
	.valid_o                  (valid_o),
	.aluop_o                  (aluop_o),
	.alusel_o                 (alusel_o),
	.wreg_o                   (wreg_o),
	.branch_flag_o            (branch_flag_o),
	.next_inst_in_delayslot_o (next_inst_in_delayslot_o)
);

// ==== test/tb_id_stage.sv ====
`timescale 1ns/1ps

module tb_id_stage import mips_id_pkg::*; ();

	localparam int STIM_CYCLES    = 600;
	localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES;

	logic                                    clk_i;
	logic                                    rst_i;
	logic                                    inst_valid_i;
	logic [WORD_W-1:0]                       inst_i;
	logic [WORD_W-1:0]                       pc_i;
	logic [NUM_OPERANDS-1:0][WORD_W-1:0]     reg_rdata_i;
	logic                                    ex_wreg_i;
	logic [REG_ADDR_W-1:0]                   ex_wd_i;
	logic [WORD_W-1:0]                       ex_wdata_i;
	alu_op_e                                 ex_aluop_i;
	logic                                    mem_wreg_i;
	logic [REG_ADDR_W-1:0]                   mem_wd_i;
	logic [WORD_W-1:0]                       mem_wdata_i;
	logic                                    stall_o;
	logic [NUM_OPERANDS-1:0][REG_ADDR_W-1:0] reg_raddr_o;
	logic                                    valid_o;
	alu_op_e                                 aluop_o;
	alu_sel_e                                alusel_o;
	logic [REG_ADDR_W-1:0]                   wd_o;
	logic                                    wreg_o;
	logic [WORD_W-1:0]                       reg1_o;
	logic [WORD_W-1:0]                       reg2_o;
	logic                                    branch_flag_o;
	logic [WORD_W-1:0]                       branch_target_o;
	logic [WORD_W-1:0]                       link_addr_o;
	logic                                    next_inst_in_delayslot_o;

	logic [31:0] rng_state = 32'h67aeb07d;
	int          cycle_count = 0;
	logic [31:0] regfile [32];

	// decode of the word being driven
	logic [4:0]  f_rs;
	logic [4:0]  f_rt;
	logic [4:0]  f_rd;
	logic [15:0] f_off;
	logic        rd_en [2];
	logic [4:0]  rd_addr [2];
	logic [31:0] imm_val;
	alu_op_e     dec_op;
	alu_sel_e    dec_sel;
	logic [4:0]  dec_wd;
	logic        dec_wreg;
	logic [31:0] dec_target;

	// expected outputs after the next edge
	logic        exp_valid;
	alu_op_e     exp_aluop;
	alu_sel_e    exp_alusel;
	logic [4:0]  exp_wd;
	logic        exp_wreg;
	logic [31:0] exp_reg1;
	logic [31:0] exp_reg2;
	logic        exp_taken;
	logic [31:0] exp_target;
	logic [31:0] exp_link;

	id_stage UUT (.*);

	assign reg_rdata_i[0] = regfile[reg_raddr_o[0]];
	assign reg_rdata_i[1] = regfile[reg_raddr_o[1]];

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	always @(posedge clk_i) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Simulation ran past %0d cycles without finishing", TIMEOUT_CYCLES);
			$display("Test failures found");
			$fatal(1);
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] rand_word();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	function automatic logic [4:0] pick_reg(input logic [1:0] sel);
		case (sel)
			2'd0:    return f_rs;
			2'd1:    return f_rt;
			2'd2:    return 5'd0;
			default: return 5'(rand_word());
		endcase
	endfunction

	// priority EX, MEM, register file; $zero never forwarded
	function automatic logic [31:0] fwd_value(input logic en, input logic [4:0] addr);
		if (!en)
			return imm_val;
		if (addr != 5'd0 && ex_wreg_i && ex_wd_i == addr)
			return ex_wdata_i;
		if (addr != 5'd0 && mem_wreg_i && mem_wd_i == addr)
			return mem_wdata_i;
		return regfile[addr];
	endfunction

	function automatic logic load_use(input logic en, input logic [4:0] addr);
		return en && addr != 5'd0 && ex_aluop_i == ALU_LW && ex_wd_i == addr;
	endfunction

	task automatic check_field(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			$display("Fail at %0t: %s = %h, expected %h", $time, name, got, exp);
			$display("Test failures found");
			$fatal(1);
		end
	endtask

	task automatic expect_decode(input alu_op_e op, input alu_sel_e sel, input logic wr,
			input logic [4:0] wd);
		dec_op   = op;
		dec_sel  = sel;
		dec_wreg = wr;
		dec_wd   = wd;
	endtask

	task automatic expect_reads(input logic en0, input logic [4:0] a0, input logic en1,
			input logic [4:0] a1, input logic [31:0] imm);
		rd_en[0]   = en0;
		rd_addr[0] = a0;
		rd_en[1]   = en1;
		rd_addr[1] = a1;
		imm_val    = imm;
	endtask

	task automatic make_rtype(input funct_e fn, input alu_op_e op, input alu_sel_e sel);
		inst_i = {6'b000000, f_rs, f_rt, f_rd, 5'd0, fn};
		expect_decode(op, sel, 1'b1, f_rd);
		expect_reads(1'b1, f_rs, 1'b1, f_rt, 32'd0);
	endtask

	task automatic make_shift(input funct_e fn, input alu_op_e op);
		inst_i = {6'b000000, 5'd0, f_rt, f_rd, f_off[10:6], fn};
		expect_decode(op, SEL_SHIFT, 1'b1, f_rd);
		expect_reads(1'b0, 5'd0, 1'b1, f_rt, {27'd0, f_off[10:6]});
	endtask

	task automatic make_itype(input opcode_e opc, input alu_op_e op, input alu_sel_e sel,
			input logic [31:0] imm);
		inst_i = {opc, f_rs, f_rt, f_off};
		expect_decode(op, sel, 1'b1, f_rt);
		expect_reads(1'b1, (opc == OP_LUI) ? 5'd0 : f_rs, 1'b0, f_rt, imm);
	endtask

	task automatic make_branch(input opcode_e opc, input logic [4:0] rt_field,
			input alu_op_e op, input logic two_regs);
		inst_i = {opc, f_rs, rt_field, f_off};
		expect_decode(op, SEL_JUMP_BRANCH, 1'b0, f_rd);
		expect_reads(1'b1, f_rs, two_regs, rt_field, 32'd0);
	endtask

	task automatic make_jump(input opcode_e opc, input alu_op_e op, input logic link);
		logic [31:0] pc4;
		pc4        = pc_i + 32'd4;
		inst_i     = {opc, f_rs, f_rt, f_off};
		dec_target = {pc4[31:28], f_rs, f_rt, f_off, 2'b00};
		expect_decode(op, SEL_JUMP_BRANCH, link, link ? LINK_REG : f_rd);
		expect_reads(1'b0, f_rs, 1'b0, f_rt, link ? pc_i + 32'd8 : 32'd0);
	endtask

	task automatic build_inst(input int kind);
		logic [31:0] r;
		logic [31:0] sext;
		r     = rand_word();
		f_rs  = r[25:21];
		f_rt  = r[20:16];
		f_rd  = r[15:11];
		f_off = r[15:0];
		if (r[31:30] == 2'b00)
			f_rt = f_rs; // equal operands for beq/bne
		if (r[29:28] == 2'b00)
			f_rs = 5'd0;
		sext       = {{16{f_off[15]}}, f_off};
		dec_target = pc_i + 32'd4 + {sext[29:0], 2'b00};
		case (kind)
			0:  make_rtype(FN_ADDU, ALU_ADDU, SEL_ARITH);
			1:  make_rtype(FN_SUBU, ALU_SUBU, SEL_ARITH);
			2:  make_rtype(FN_AND, ALU_AND, SEL_LOGIC);
			3:  make_rtype(FN_OR, ALU_OR, SEL_LOGIC);
			4:  make_rtype(FN_XOR, ALU_XOR, SEL_LOGIC);
			5:  make_rtype(FN_NOR, ALU_NOR, SEL_LOGIC);
			6:  make_rtype(FN_SLT, ALU_SLT, SEL_ARITH);
			7:  make_rtype(FN_SLTU, ALU_SLTU, SEL_ARITH);
			8:  make_shift(FN_SLL, ALU_SLL);
			9:  make_shift(FN_SRL, ALU_SRL);
			10: make_shift(FN_SRA, ALU_SRA);
			11: make_itype(OP_ADDIU, ALU_ADDU, SEL_ARITH, sext);
			12: make_itype(OP_SLTI, ALU_SLT, SEL_ARITH, sext);
			13: make_itype(OP_ANDI, ALU_AND, SEL_LOGIC, {16'd0, f_off});
			14: make_itype(OP_ORI, ALU_OR, SEL_LOGIC, {16'd0, f_off});
			15: make_itype(OP_XORI, ALU_XOR, SEL_LOGIC, {16'd0, f_off});
			16: make_itype(OP_LUI, ALU_OR, SEL_LOGIC, {f_off, 16'd0});
			17: make_itype(OP_LW, ALU_LW, SEL_LOAD_STORE, sext);
			18: begin
				inst_i = {OP_SW, f_rs, f_rt, f_off};
				expect_decode(ALU_SW, SEL_LOAD_STORE, 1'b0, f_rd);
				expect_reads(1'b1, f_rs, 1'b1, f_rt, sext);
			end
			19: make_branch(OP_BEQ, f_rt, ALU_BEQ, 1'b1);
			20: make_branch(OP_BNE, f_rt, ALU_BNE, 1'b1);
			21: make_branch(OP_BLEZ, f_rt, ALU_BLEZ, 1'b0);
			22: make_branch(OP_BGTZ, f_rt, ALU_BGTZ, 1'b0);
			23: make_branch(OP_REGIMM, RI_BGEZ, ALU_BGEZ, 1'b0);
			24: make_branch(OP_REGIMM, RI_BLTZ, ALU_BLTZ, 1'b0);
			25: make_jump(OP_J, ALU_J, 1'b0);
			26: make_jump(OP_JAL, ALU_JAL, 1'b1);
			27: begin
				inst_i = {6'b000000, f_rs, 15'd0, FN_JR};
				expect_decode(ALU_JR, SEL_JUMP_BRANCH, 1'b0, f_rd);
				expect_reads(1'b1, f_rs, 1'b0, 5'd0, 32'd0);
			end
			default: begin
				inst_i = {6'b111111, r[25:0]}; // unused opcode
				expect_decode(ALU_NOP, SEL_NOP, 1'b0, f_rd);
				expect_reads(1'b0, f_rs, 1'b0, f_rt, 32'd0);
			end
		endcase
	endtask

	task automatic drive_cycle();
		logic [31:0] r;
		logic [31:0] op0;
		logic [31:0] op1;
		logic        stall;
		logic        taken;
		r            = rand_word();
		pc_i         = rand_word() & 32'hffff_fffc;
		inst_valid_i = (r[2:0] != 3'd0);
		build_inst(int'(rand_word() % 32'd29));
		ex_wreg_i    = r[3];
		ex_wd_i      = pick_reg(r[5:4]);
		ex_wdata_i   = rand_word();
		ex_aluop_i   = (r[8:6] == 3'd0) ? ALU_LW : ALU_ADDU;
		if (r[8:6] == 3'd0)
			ex_wreg_i = 1'b1; // a load in EX always writes
		mem_wreg_i   = r[9];
		mem_wd_i     = pick_reg(r[11:10]);
		mem_wdata_i  = rand_word();
		stall = load_use(rd_en[0], rd_addr[0]) || load_use(rd_en[1], rd_addr[1]);
		op0   = fwd_value(rd_en[0], rd_addr[0]);
		op1   = fwd_value(rd_en[1], rd_addr[1]);
		case (dec_op)
			ALU_BEQ:                taken = (op0 == op1);
			ALU_BNE:                taken = (op0 != op1);
			ALU_BLEZ:               taken = ($signed(op0) <= 0);
			ALU_BGTZ:               taken = ($signed(op0) > 0);
			ALU_BGEZ:               taken = ($signed(op0) >= 0);
			ALU_BLTZ:               taken = ($signed(op0) < 0);
			ALU_J, ALU_JAL, ALU_JR: taken = 1'b1;
			default:                taken = 1'b0;
		endcase
		if (dec_op == ALU_JR)
			dec_target = op0;
		exp_valid  = inst_valid_i && !stall;
		exp_aluop  = exp_valid ? dec_op : ALU_NOP;
		exp_alusel = exp_valid ? dec_sel : SEL_NOP;
		exp_wd     = dec_wd;
		exp_wreg   = exp_valid && dec_wreg;
		exp_reg1   = op0;
		exp_reg2   = op1;
		exp_taken  = exp_valid && taken;
		exp_target = dec_target;
		exp_link   = (dec_op == ALU_JAL) ? pc_i + 32'd8 : 32'd0;
		#1;
		check_field("stall_o", 32'(stall_o), 32'(stall));
		if (rd_en[0])
			check_field("reg_raddr_o[0]", 32'(reg_raddr_o[0]), 32'(rd_addr[0]));
		if (rd_en[1])
			check_field("reg_raddr_o[1]", 32'(reg_raddr_o[1]), 32'(rd_addr[1]));
	endtask

	task automatic check_outputs();
		check_field("valid_o", 32'(valid_o), 32'(exp_valid));
		check_field("aluop_o", 32'(aluop_o), 32'(exp_aluop));
		check_field("alusel_o", 32'(alusel_o), 32'(exp_alusel));
		check_field("wreg_o", 32'(wreg_o), 32'(exp_wreg));
		check_field("branch_flag_o", 32'(branch_flag_o), 32'(exp_taken));
		check_field("next_inst_in_delayslot_o", 32'(next_inst_in_delayslot_o),
			32'(exp_taken));
		if (exp_valid) begin
			check_field("reg1_o", reg1_o, exp_reg1);
			check_field("reg2_o", reg2_o, exp_reg2);
			check_field("link_addr_o", link_addr_o, exp_link);
		end
		if (exp_wreg)
			check_field("wd_o", 32'(wd_o), 32'(exp_wd));
		if (exp_taken)
			check_field("branch_target_o", branch_target_o, exp_target);
	endtask

	initial begin
		for (int i = 1; i < 32; i++)
			regfile[i] = rand_word();
		regfile[0]   = 32'd0;
		rst_i        = 1'b1;
		inst_valid_i = 1'b0;
		inst_i       = 32'd0;
		pc_i         = 32'd0;
		ex_wreg_i    = 1'b0;
		ex_wd_i      = 5'd0;
		ex_wdata_i   = 32'd0;
		ex_aluop_i   = ALU_NOP;
		mem_wreg_i   = 1'b0;
		mem_wd_i     = 5'd0;
		mem_wdata_i  = 32'd0;
		exp_valid    = 1'b0;
		exp_aluop    = ALU_NOP;
		exp_alusel   = SEL_NOP;
		exp_wreg     = 1'b0;
		exp_taken    = 1'b0;
		repeat (2) @(posedge clk_i);
		#1;
		rst_i = 1'b0;
		check_outputs(); // reset state
		for (int n = 0; n < STIM_CYCLES; n++) begin
			drive_cycle();
			@(posedge clk_i);
			#1;
			check_outputs();
		end
		if (UUT.u_props.fail_count == 0) begin
			$display("All tests passed!");
			$finish;
		end else begin
			$display("%0d protocol assertions failed", UUT.u_props.fail_count);
			$display("Test failures found");
			$fatal(1);
		end
	end

endmodule
